// File: design/bram_fifo_config.svh
//////////////////////////////////////////////////
// bram fifo configuration
// default depth, threshold percentages, register
// address width and version code
//////////////////////////////////////////////////
`ifndef BRAM_FIFO_CONFIG_SVH
`define BRAM_FIFO_CONFIG_SVH

`define BRAM_FIFO_DEPTH      64   // words, small for simulation
`define BRAM_FIFO_AFULL_PCT  95   // almost-full, percent of depth
`define BRAM_FIFO_AEMPTY_PCT 5    // almost-empty, percent of depth

`define BRAM_FIFO_ABUSWIDTH  32   // register port address width

`define BRAM_FIFO_VERSION    2    // returned at register address 0

`endif

// File: design/bram_fifo_regs_pkg.sv
//////////////////////////////////////////////////
// bram fifo register types
// address map of the byte-wide register port
//////////////////////////////////////////////////
package bram_fifo_regs_pkg;

    // byte register addresses, low three address bits
    typedef enum logic [2:0] {
        REG_VERSION_RST  = 3'd0, // read version, write soft reset
        REG_ALMOST_FULL  = 3'd1, // 1/256ths of depth
        REG_ALMOST_EMPTY = 3'd2, // 1/256ths of depth
        REG_READ_ERRORS  = 3'd3, // pops while empty, saturating
        REG_SIZE_B0      = 3'd4, // live, latches upper bytes
        REG_SIZE_B1      = 3'd5, // latched
        REG_SIZE_B2      = 3'd6, // latched
        REG_SIZE_B3      = 3'd7  // latched
    } reg_addr_e;

    // one register byte
    typedef logic [7:0] reg_byte_t;

endpackage

// File: design/bram_fifo_data_pkg.sv
//////////////////////////////////////////////////
// bram fifo data types
// buffer word and fill count
//////////////////////////////////////////////////
package bram_fifo_data_pkg;

    // one buffered word, as seen on both data ports
    typedef logic [31:0] word_t;

    // fill level in words
    // only the low log2(depth)+1 bits are ever nonzero,
    // so a completely full buffer still fits
    typedef logic [31:0] fill_t;

endpackage

// File: design/fifo_status_if.sv
//////////////////////////////////////////////////
// fifo status interface
// fill level and flags from storage, reset back
//////////////////////////////////////////////////
`timescale 1ns/1ns

interface fifo_status_if;

    bram_fifo_data_pkg::fill_t fill;  // words held
    logic                      empty;
    logic                      full;
    logic                      fifo_rst; // bus reset or soft reset

    modport mem_side (
        input  fifo_rst,
        output fill,
        output empty,
        output full
    );

    modport regs_side (
        output fifo_rst,
        input  fill,
        input  empty,
        input  full
    );

endinterface

// File: design/bram_fifo_mem.sv
//////////////////////////////////////////////////
// bram fifo storage
// word array with write and read pointers, fill
// count, flags and a registered head word
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "bram_fifo_config.svh"

module bram_fifo_mem
#(
    parameter int depth = `BRAM_FIFO_DEPTH
)
(
    input  logic                      BUS_CLK,
    input  logic                      wr_bus,
    input  bram_fifo_data_pkg::word_t wr_bus_data,
    input  logic                      src_empty,
    input  bram_fifo_data_pkg::word_t src_data,
    input  logic                      rd,
    output bram_fifo_data_pkg::word_t head_data,
    fifo_status_if.mem_side           status
);

    localparam int ptr_w  = $clog2(depth);
    localparam int fill_w = ptr_w + 1;

    bram_fifo_data_pkg::word_t mem [depth];

    logic [ptr_w-1:0]          wr_ptr;
    logic [ptr_w-1:0]          rd_ptr;
    logic [fill_w-1:0]         fill_cnt;
    logic                      wr_en;
    logic                      rd_en;
    bram_fifo_data_pkg::word_t wr_word;

    // pointer advance, wraps for any depth
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_en   = (wr_bus || !src_empty) && !status.full; // bus or source
    assign rd_en   = rd && !status.empty;
    assign wr_word = wr_bus ? wr_bus_data : src_data;         // bus wins

    always_ff @(posedge BUS_CLK)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (status.fifo_rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en)
            begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   fill_cnt <= fill_cnt + 1'b1;
                2'b01:   fill_cnt <= fill_cnt - 1'b1;
                default: fill_cnt <= fill_cnt; // both or neither
            endcase
        end
    end

    // head word shows up one cycle after it changes
    always_ff @(posedge BUS_CLK)
    begin
        head_data <= mem[rd_ptr];
    end

    assign status.fill  = bram_fifo_data_pkg::fill_t'(fill_cnt);
    assign status.empty = (fill_cnt == '0);
    assign status.full  = (fill_cnt == fill_w'(depth));

    // fill count never passes the depth
    a_fill_bound: assert property (
        @(posedge BUS_CLK) disable iff (status.fifo_rst)
        fill_cnt <= fill_w'(depth)
    );

    // underflowing pop must not move the read side
    a_empty_pop: assert property (
        @(posedge BUS_CLK) disable iff (status.fifo_rst)
        (rd && status.empty) |=> $stable(rd_ptr)
    );

endmodule

// File: design/bram_fifo_ctrl_regs.sv
//////////////////////////////////////////////////
// bram fifo control registers
// byte register file, soft reset, read-error
// count, size snapshot and near-full flag
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "bram_fifo_config.svh"

module bram_fifo_ctrl_regs
#(
    parameter int depth      = `BRAM_FIFO_DEPTH,
    parameter int afull_pct  = `BRAM_FIFO_AFULL_PCT,
    parameter int aempty_pct = `BRAM_FIFO_AEMPTY_PCT
)
(
    input  logic                             BUS_CLK,
    input  logic                             RST,
    input  logic [`BRAM_FIFO_ABUSWIDTH-1:0]  bus_add,
    input  bram_fifo_regs_pkg::reg_byte_t    bus_data_in,
    input  logic                             bus_wr,
    input  logic                             bus_rd,
    input  logic                             bus_rd_data,
    output bram_fifo_regs_pkg::reg_byte_t    bus_data_out,
    output logic                             near_full,
    output logic                             read_error,
    fifo_status_if.regs_side                 status
);

    localparam int abw = `BRAM_FIFO_ABUSWIDTH;

    localparam bram_fifo_regs_pkg::reg_byte_t afull_default =
        bram_fifo_regs_pkg::reg_byte_t'(255 * afull_pct / 100);
    localparam bram_fifo_regs_pkg::reg_byte_t aempty_default =
        bram_fifo_regs_pkg::reg_byte_t'(255 * aempty_pct / 100);
    localparam bram_fifo_regs_pkg::reg_byte_t version =
        bram_fifo_regs_pkg::reg_byte_t'(`BRAM_FIFO_VERSION);

    bram_fifo_regs_pkg::reg_byte_t reg_file [8];
    bram_fifo_regs_pkg::reg_byte_t rd_errors;
    bram_fifo_regs_pkg::reg_byte_t almost_full;
    bram_fifo_regs_pkg::reg_byte_t almost_empty;
    bram_fifo_regs_pkg::reg_addr_e addr;
    bram_fifo_data_pkg::fill_t     size_bytes;
    bram_fifo_data_pkg::fill_t     afull_level;
    bram_fifo_data_pkg::fill_t     aempty_level;
    logic [31:8]                   size_snap;
    logic                          addr_in_map;
    logic                          soft_rst;

    assign addr_in_map = (bus_add[abw-1:3] == '0); // only eight bytes decoded
    assign addr        = bram_fifo_regs_pkg::reg_addr_e'(bus_add[2:0]);
    assign soft_rst    = bus_wr && addr_in_map && (addr == bram_fifo_regs_pkg::REG_VERSION_RST);

    assign status.fifo_rst = RST || soft_rst;

    // register bytes, address 0 never stores
    always_ff @(posedge BUS_CLK)
    begin
        if (status.fifo_rst)
        begin
            for (int i = 0; i < 8; i++)
            begin
                reg_file[i] <= '0;
            end
            reg_file[bram_fifo_regs_pkg::REG_ALMOST_FULL]  <= afull_default;
            reg_file[bram_fifo_regs_pkg::REG_ALMOST_EMPTY] <= aempty_default;
        end
        else if (bus_wr && addr_in_map)
        begin
            reg_file[addr] <= bus_data_in;
        end
    end

    assign almost_full  = reg_file[bram_fifo_regs_pkg::REG_ALMOST_FULL];
    assign almost_empty = reg_file[bram_fifo_regs_pkg::REG_ALMOST_EMPTY];

    // pops attempted on an empty buffer
    always_ff @(posedge BUS_CLK)
    begin
        if (status.fifo_rst)
        begin
            rd_errors <= '0;
        end
        else if (bus_rd_data && status.empty && rd_errors != 8'hff)
        begin
            rd_errors <= rd_errors + 1'b1;
        end
    end

    assign read_error = (rd_errors != '0);

    assign size_bytes = status.fill << 2; // words to bytes

    // byte 0 read freezes the upper three bytes
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            size_snap <= '0;
        end
        else if (bus_rd && addr_in_map && addr == bram_fifo_regs_pkg::REG_SIZE_B0)
        begin
            size_snap <= size_bytes[31:8];
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (!addr_in_map)
        begin
            bus_data_out <= '0;
        end
        else
        begin
            case (addr)
                bram_fifo_regs_pkg::REG_VERSION_RST:  bus_data_out <= version;
                bram_fifo_regs_pkg::REG_ALMOST_FULL:  bus_data_out <= almost_full;
                bram_fifo_regs_pkg::REG_ALMOST_EMPTY: bus_data_out <= almost_empty;
                bram_fifo_regs_pkg::REG_READ_ERRORS:  bus_data_out <= rd_errors;
                bram_fifo_regs_pkg::REG_SIZE_B0:      bus_data_out <= size_bytes[7:0];
                bram_fifo_regs_pkg::REG_SIZE_B1:      bus_data_out <= size_snap[15:8];
                bram_fifo_regs_pkg::REG_SIZE_B2:      bus_data_out <= size_snap[23:16];
                bram_fifo_regs_pkg::REG_SIZE_B3:      bus_data_out <= size_snap[31:24];
                default:                              bus_data_out <= '0;
            endcase
        end
    end

    // thresholds in words, rounded down
    assign afull_level  = ((bram_fifo_data_pkg::fill_t'(almost_full) + 1)
                           * bram_fifo_data_pkg::fill_t'(depth)) >> 8;
    assign aempty_level = ((bram_fifo_data_pkg::fill_t'(almost_empty) + 1)
                           * bram_fifo_data_pkg::fill_t'(depth)) >> 8;

    // set high, clear low, hold in between
    always_ff @(posedge BUS_CLK)
    begin
        if (status.fifo_rst)
        begin
            near_full <= 1'b0;
        end
        else if (status.fill >= afull_level || almost_full == '0)
        begin
            near_full <= 1'b1;
        end
        else if ((almost_empty != '0 && status.fill <= aempty_level) || status.fill == '0)
        begin
            near_full <= 1'b0;
        end
    end

    // saturated counter stays at 255 until a reset
    a_err_saturate: assert property (
        @(posedge BUS_CLK) disable iff (status.fifo_rst)
        (rd_errors == 8'hff) |=> (rd_errors == 8'hff)
    );

    // a drained buffer drops the flag unless the set level is zero
    a_near_full_clear: assert property (
        @(posedge BUS_CLK) disable iff (RST)
        (status.fill == '0 && almost_full != '0 && afull_level != '0) |=> !near_full
    );

endmodule

// File: design/bram_fifo_core.sv
//////////////////////////////////////////////////
// bram fifo core
// word buffer with byte register port, top level
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "bram_fifo_config.svh"

module bram_fifo_core
(
    input  logic                            BUS_CLK,
    input  logic                            BUS_RST,
    input  logic [`BRAM_FIFO_ABUSWIDTH-1:0] BUS_ADD,
    input  logic [7:0]                      BUS_DATA_IN,
    input  logic                            BUS_RD,
    input  logic                            BUS_WR,
    output logic [7:0]                      BUS_DATA_OUT,

    input  logic                            BUS_RD_DATA,
    output logic [31:0]                     BUS_DATA_OUT_DATA,
    input  logic                            BUS_WR_DATA,
    input  logic [31:0]                     BUS_DATA_IN_DATA,

    output logic                            FIFO_READ_NEXT_OUT,
    input  logic                            FIFO_EMPTY_IN,
    input  logic [31:0]                     FIFO_DATA,

    output logic                            FIFO_NOT_EMPTY,
    output logic                            FIFO_FULL,
    output logic                            FIFO_NEAR_FULL,
    output logic                            FIFO_READ_ERROR
);

    fifo_status_if status ();

    bram_fifo_mem #(
        .depth       (`BRAM_FIFO_DEPTH)
    ) i_mem (
        .BUS_CLK     (BUS_CLK),
        .wr_bus      (BUS_WR_DATA),
        .wr_bus_data (BUS_DATA_IN_DATA),
        .src_empty   (FIFO_EMPTY_IN),
        .src_data    (FIFO_DATA),
        .rd          (BUS_RD_DATA),
        .head_data   (BUS_DATA_OUT_DATA),
        .status      (status.mem_side)
    );

    bram_fifo_ctrl_regs #(
        .depth        (`BRAM_FIFO_DEPTH),
        .afull_pct    (`BRAM_FIFO_AFULL_PCT),
        .aempty_pct   (`BRAM_FIFO_AEMPTY_PCT)
    ) i_regs (
        .BUS_CLK      (BUS_CLK),
        .RST          (BUS_RST),
        .bus_add      (BUS_ADD),
        .bus_data_in  (BUS_DATA_IN),
        .bus_wr       (BUS_WR),
        .bus_rd       (BUS_RD),
        .bus_rd_data  (BUS_RD_DATA),
        .bus_data_out (BUS_DATA_OUT),
        .near_full    (FIFO_NEAR_FULL),
        .read_error   (FIFO_READ_ERROR),
        .status       (status.regs_side)
    );

    assign FIFO_READ_NEXT_OUT = !status.full;  // source may advance
    assign FIFO_NOT_EMPTY     = !status.empty;
    assign FIFO_FULL          = status.full;

endmodule

// File: sim/bram_fifo_checker.sv
//////////////////////////////////////////////////
// bram fifo checker
// queue and register model of the buffer, compares
// every DUT output each cycle and counts errors
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "bram_fifo_config.svh"

module bram_fifo_checker
(
    input  logic                            BUS_CLK,
    input  logic                            RST,
    input  logic [`BRAM_FIFO_ABUSWIDTH-1:0] BUS_ADD,
    input  bram_fifo_regs_pkg::reg_byte_t   BUS_DATA_IN,
    input  logic                            BUS_RD,
    input  logic                            BUS_WR,
    input  bram_fifo_regs_pkg::reg_byte_t   BUS_DATA_OUT,
    input  logic                            BUS_RD_DATA,
    input  bram_fifo_data_pkg::word_t       BUS_DATA_OUT_DATA,
    input  logic                            BUS_WR_DATA,
    input  bram_fifo_data_pkg::word_t       BUS_DATA_IN_DATA,
    input  logic                            FIFO_READ_NEXT_OUT,
    input  logic                            FIFO_EMPTY_IN,
    input  bram_fifo_data_pkg::word_t       FIFO_DATA,
    input  logic                            FIFO_NOT_EMPTY,
    input  logic                            FIFO_FULL,
    input  logic                            FIFO_NEAR_FULL,
    input  logic                            FIFO_READ_ERROR,
    input  logic                            exp_en,   // table expects a register byte
    input  bram_fifo_regs_pkg::reg_byte_t   exp_byte,
    output int                              checks,
    output int                              errors
);

    localparam int depth      = `BRAM_FIFO_DEPTH;
    localparam int afull_def  = 255 * `BRAM_FIFO_AFULL_PCT / 100;
    localparam int aempty_def = 255 * `BRAM_FIFO_AEMPTY_PCT / 100;

    bram_fifo_data_pkg::word_t     q [$];        // words held, head first
    bram_fifo_data_pkg::word_t     head_exp;
    bram_fifo_regs_pkg::reg_byte_t dout_exp;
    bram_fifo_regs_pkg::reg_byte_t tab_byte;
    int   err  = 0;
    int   af   = afull_def;
    int   ae   = aempty_def;
    int   snap = 0;                              // latched size in bytes
    logic nf       = 1'b0;
    logic head_ok  = 1'b0;
    logic dout_ok  = 1'b0;
    logic tab_en   = 1'b0;
    logic started  = 1'b0;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // one clock edge of the model, inputs are stable here
    always @(posedge BUS_CLK)
    begin : model_step
        int fill;
        fill     = q.size();
        started  = 1'b1;
        tab_en   = exp_en;
        tab_byte = exp_byte;
        head_ok  = (fill != 0) && !RST;
        if (fill != 0)
            head_exp = q[0];
        dout_ok = !RST;
        case (BUS_ADD)
            0:       dout_exp = 8'(`BRAM_FIFO_VERSION);
            1:       dout_exp = 8'(af);
            2:       dout_exp = 8'(ae);
            3:       dout_exp = 8'(err);
            4:       dout_exp = 8'(fill * 4);     // live low byte
            5:       dout_exp = 8'(snap >> 8);
            6:       dout_exp = 8'(snap >> 16);
            7:       dout_exp = 8'(snap >> 24);
            default: dout_exp = 8'd0;
        endcase
        if (RST)
            snap = 0;
        else if (BUS_RD && BUS_ADD == bram_fifo_regs_pkg::REG_SIZE_B0)
            snap = fill * 4;
        if (RST || (BUS_WR && BUS_ADD == bram_fifo_regs_pkg::REG_VERSION_RST))
        begin
            q.delete();
            err = 0;
            af  = afull_def;
            ae  = aempty_def;
            nf  = 1'b0;
        end
        else
        begin
            // hysteresis uses the thresholds before this edge
            if (fill >= ((af + 1) * depth) / 256 || af == 0)
                nf = 1'b1;
            else if ((ae != 0 && fill <= ((ae + 1) * depth) / 256) || fill == 0)
                nf = 1'b0;
            if (BUS_WR && BUS_ADD == 1)
                af = int'(BUS_DATA_IN);
            if (BUS_WR && BUS_ADD == 2)
                ae = int'(BUS_DATA_IN);
            if (BUS_RD_DATA && fill == 0 && err < 255)
                err++;
            if (BUS_RD_DATA && fill != 0)
                void'(q.pop_front());
            if ((BUS_WR_DATA || !FIFO_EMPTY_IN) && fill < depth)
                q.push_back(BUS_WR_DATA ? BUS_DATA_IN_DATA : FIFO_DATA); // bus wins
        end
    end

    // outputs settle well before the falling edge
    always @(negedge BUS_CLK)
    begin
        if (started)
        begin
            compare("FIFO_NOT_EMPTY", 32'(FIFO_NOT_EMPTY), 32'(q.size() != 0));
            compare("FIFO_FULL", 32'(FIFO_FULL), 32'(q.size() == depth));
            compare("FIFO_READ_NEXT_OUT", 32'(FIFO_READ_NEXT_OUT), 32'(q.size() != depth));
            compare("FIFO_NEAR_FULL", 32'(FIFO_NEAR_FULL), 32'(nf));
            compare("FIFO_READ_ERROR", 32'(FIFO_READ_ERROR), 32'(err != 0));
            if (dout_ok)
                compare("BUS_DATA_OUT", 32'(BUS_DATA_OUT), 32'(dout_exp));
            if (tab_en)
                compare("BUS_DATA_OUT vs table", 32'(BUS_DATA_OUT), 32'(tab_byte));
            if (head_ok)
                compare("BUS_DATA_OUT_DATA", BUS_DATA_OUT_DATA, head_exp);
        end
    end

endmodule

// File: sim/tb_bram_fifo.sv
//////////////////////////////////////////////////
// bram fifo testbench
// walks a stimulus table through the core
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "bram_fifo_config.svh"

module tb_bram_fifo;

    typedef enum logic [2:0] {BUS_WRITE_REG, BUS_READ_REG, SRC_PUSH, BUS_PUSH, POP, IDLE} op_e;

    typedef struct packed
    {
        op_e         op;
        int          arg;   // address, or count of cycles
        logic [31:0] data;  // write byte, expected byte, or source also offers
    } entry_t;

    localparam int num_entries = 30;
    localparam int watchdog_ns = (num_entries * 70 + 100) * 10;

    entry_t stim [num_entries] = '{
        '{BUS_READ_REG, 0, 2}, '{BUS_READ_REG, 1, 242}, '{BUS_READ_REG, 2, 12},
        '{POP, 3, 0},                                  // pops on an empty buffer
        '{BUS_READ_REG, 3, 3},
        '{SRC_PUSH, 5, 0}, '{BUS_PUSH, 3, 1},          // bus and source at once
        '{POP, 8, 0},
        '{SRC_PUSH, 63, 0}, '{BUS_READ_REG, 4, 252},   // latch at 252 bytes
        '{SRC_PUSH, 1, 0}, '{BUS_READ_REG, 5, 0},      // still the latched byte
        '{SRC_PUSH, 4, 0},                             // dropped while full
        '{BUS_READ_REG, 4, 0}, '{BUS_READ_REG, 5, 1},  // 256 bytes
        '{POP, 60, 0}, '{IDLE, 2, 0}, '{POP, 1, 0}, '{IDLE, 2, 0},
        '{BUS_WRITE_REG, 1, 0}, '{IDLE, 2, 0},         // zero almost-full sets flag
        '{BUS_WRITE_REG, 2, 40},
        '{POP, 5, 0}, '{BUS_READ_REG, 3, 5},
        '{SRC_PUSH, 4, 0},                             // words held at soft reset
        '{BUS_WRITE_REG, 0, 0},                        // soft reset
        '{BUS_READ_REG, 1, 242}, '{BUS_READ_REG, 2, 12},
        '{BUS_READ_REG, 3, 0}, '{BUS_READ_REG, 0, 2}
    };

    logic                            BUS_CLK = 1'b0;
    logic                            RST;
    logic [`BRAM_FIFO_ABUSWIDTH-1:0] BUS_ADD;
    logic [7:0]                      BUS_DATA_IN;
    logic                            BUS_RD;
    logic                            BUS_WR;
    logic [7:0]                      BUS_DATA_OUT;
    logic                            BUS_RD_DATA;
    logic [31:0]                     BUS_DATA_OUT_DATA;
    logic                            BUS_WR_DATA;
    logic [31:0]                     BUS_DATA_IN_DATA;
    logic                            FIFO_READ_NEXT_OUT;
    logic                            FIFO_EMPTY_IN;
    logic [31:0]                     FIFO_DATA;
    logic                            FIFO_NOT_EMPTY;
    logic                            FIFO_FULL;
    logic                            FIFO_NEAR_FULL;
    logic                            FIFO_READ_ERROR;
    logic                            exp_en;
    logic [7:0]                      exp_byte;
    int                              checks;
    int                              errors;
    logic [31:0]                     rng = 32'd30301;

    bram_fifo_core uut (.BUS_RST(RST), .*);

    bram_fifo_checker i_checker (.*);

    always #5 BUS_CLK = ~BUS_CLK;

    // xorshift32 step
    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic drive_idle();
        BUS_ADD          = '0;
        BUS_DATA_IN      = '0;
        BUS_RD           = 1'b0;
        BUS_WR           = 1'b0;
        BUS_RD_DATA      = 1'b0;
        BUS_WR_DATA      = 1'b0;
        BUS_DATA_IN_DATA = '0;
        FIFO_EMPTY_IN    = 1'b1;  // source has nothing
        FIFO_DATA        = '0;
        exp_en           = 1'b0;
        exp_byte         = '0;
    endtask

    task automatic run_entry(input entry_t e);
        int n;
        n = (e.op == BUS_WRITE_REG || e.op == BUS_READ_REG) ? 1 : e.arg;
        for (int i = 0; i < n; i++)
        begin
            @(negedge BUS_CLK);
            drive_idle();
            case (e.op)
                BUS_WRITE_REG:
                begin
                    BUS_ADD     = e.arg;
                    BUS_DATA_IN = e.data[7:0];
                    BUS_WR      = 1'b1;
                end
                BUS_READ_REG:
                begin
                    BUS_ADD  = e.arg;
                    BUS_RD   = 1'b1;
                    exp_en   = 1'b1;
                    exp_byte = e.data[7:0];
                end
                SRC_PUSH:
                begin
                    FIFO_EMPTY_IN = 1'b0;
                    FIFO_DATA     = next_rand();
                end
                BUS_PUSH:
                begin
                    BUS_WR_DATA      = 1'b1;
                    BUS_DATA_IN_DATA = next_rand();
                    FIFO_EMPTY_IN    = !e.data[0];
                    FIFO_DATA        = next_rand();
                end
                POP:     BUS_RD_DATA = 1'b1;
                default: drive_idle();
            endcase
        end
    endtask

    initial
    begin
        RST = 1'b1;
        drive_idle();
        repeat (5) @(negedge BUS_CLK);
        RST = 1'b0;
        foreach (stim[k])
            run_entry(stim[k]);
        @(negedge BUS_CLK);
        drive_idle();
        repeat (3) @(negedge BUS_CLK); // last read reaches the checker
        $display("closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        $display("timeout: the stimulus table did not finish in %0d ns", watchdog_ns);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+design
design/bram_fifo_regs_pkg.sv
design/bram_fifo_data_pkg.sv
design/fifo_status_if.sv
design/bram_fifo_mem.sv
design/bram_fifo_ctrl_regs.sv
design/bram_fifo_core.sv
sim/bram_fifo_checker.sv
sim/tb_bram_fifo.sv

// File: Makefile
# Verilator flow for the bram fifo testbench

VERILATOR ?= verilator
TOP       ?= tb_bram_fifo
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ns

SOURCES := $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# a crashed run counts as a failed one
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "ERRORS FOUND" >> $(LOG)
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
